//--- rtl/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// frame geometry
`define CONV_IMG_WIDTH   8
`define CONV_IMG_HEIGHT  8

// 3x3 window
`define CONV_KERNEL      3
`define CONV_TAPS        9

`define CONV_CHANNELS    4

// Q8.8 data words
`define CONV_WORD        16
`define CONV_FRAC        8

// 36 weights followed by 4 biases
`define CONV_COEFF_COUNT 40

`endif

//--- rtl/conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

	// one Q8.8 word, for pixels, weights, biases and channel results
	typedef logic signed [`CONV_WORD-1:0] pixel_t;

	// wide enough for a full product or a partial sum
	typedef logic signed [2*`CONV_WORD-1:0] acc_t;

	// tap 0 is the oldest row's leftmost pixel
	typedef pixel_t [`CONV_TAPS-1:0] tap_vec_t;

	typedef pixel_t [`CONV_CHANNELS-1:0] chan_vec_t;

	// indexed [tap][channel]
	typedef pixel_t [`CONV_TAPS-1:0][`CONV_CHANNELS-1:0] weight_mat_t;
	typedef pixel_t [`CONV_TAPS-1:0][`CONV_CHANNELS-1:0] prod_mat_t;

	typedef logic [`CONV_WORD-1:0] coord_t;

endpackage

//--- rtl/coeff_loader.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module coeff_loader (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  coeff_valid,
	input  conv_pkg::pixel_t      coeff_data,
	output logic                  coeff_ready,
	output logic                  coeff_loaded,
	output conv_pkg::weight_mat_t weights,
	output conv_pkg::chan_vec_t   biases
);

	localparam int CNT_W        = $clog2(`CONV_COEFF_COUNT + 1);
	localparam int WEIGHT_COUNT = `CONV_TAPS * `CONV_CHANNELS;

	logic [CNT_W-1:0] load_count;
	logic             load_fire;
	logic             is_weight;

	assign coeff_loaded = (load_count == CNT_W'(`CONV_COEFF_COUNT));
	assign coeff_ready  = !coeff_loaded;
	assign load_fire    = coeff_valid && coeff_ready;
	assign is_weight    = (load_count < CNT_W'(WEIGHT_COUNT));

	// word index stops at the full count
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			load_count <= '0;
		end
		else if (load_fire)
		begin
			load_count <= load_count + 1'b1;
		end
	end

	// weights arrive tap-major, channel-minor, then one bias per channel
	always_ff @(posedge clk)
	begin
		if (load_fire)
		begin
			if (is_weight)
			begin
				weights[load_count / `CONV_CHANNELS][load_count % `CONV_CHANNELS] <= coeff_data;
			end
			else
			begin
				biases[load_count - CNT_W'(WEIGHT_COUNT)] <= coeff_data;
			end
		end
	end

	// once loaded, the set stays fixed until reset
	a_no_reload: assert property (@(posedge clk) disable iff (rst)
		coeff_loaded |=> coeff_loaded && $stable(weights) && $stable(biases));

endmodule

//--- rtl/conv_window.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_window (
	input  logic               clk,
	input  logic               rst,
	input  logic               en,
	input  logic               in_fire,
	input  conv_pkg::pixel_t   in_data,
	output logic               win_valid,
	output conv_pkg::tap_vec_t win,
	output conv_pkg::coord_t   win_row,
	output conv_pkg::coord_t   win_col,
	output logic               win_last
);

	import conv_pkg::*;

	localparam int EDGE  = `CONV_KERNEL - 1;
	localparam int COL_W = $clog2(`CONV_IMG_WIDTH);

	// row r-2 and row r-1, one word per column
	pixel_t row_top [`CONV_IMG_WIDTH];
	pixel_t row_mid [`CONV_IMG_WIDTH];

	pixel_t           col_in [`CONV_KERNEL];
	coord_t           col_cnt;
	coord_t           row_cnt;
	logic [COL_W-1:0] col_idx;
	logic             col_end;
	logic             row_end;
	logic             pos_ok;

	assign col_idx = col_cnt[COL_W-1:0];
	assign col_end = (col_cnt == coord_t'(`CONV_IMG_WIDTH - 1));
	assign row_end = (row_cnt == coord_t'(`CONV_IMG_HEIGHT - 1));
	assign pos_ok  = (row_cnt >= coord_t'(EDGE)) && (col_cnt >= coord_t'(EDGE));

	// new column entering the window, oldest row first
	assign col_in[0] = row_top[col_idx];
	assign col_in[1] = row_mid[col_idx];
	assign col_in[2] = in_data;

	always_ff @(posedge clk)
	begin
		if (in_fire)
		begin
			row_top[col_idx] <= row_mid[col_idx];
			row_mid[col_idx] <= in_data;
			for (int k = 0; k < `CONV_KERNEL; k++)
			begin
				for (int j = 0; j < EDGE; j++)
				begin
					win[k*`CONV_KERNEL + j] <= win[k*`CONV_KERNEL + j + 1];
				end
				win[k*`CONV_KERNEL + EDGE] <= col_in[k];
			end
			// position of the window's top-left corner
			win_row <= coord_t'(row_cnt - EDGE);
			win_col <= coord_t'(col_cnt - EDGE);
		end
	end

	// raster position of the next pixel
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			col_cnt <= '0;
			row_cnt <= '0;
		end
		else if (in_fire)
		begin
			if (col_end)
			begin
				col_cnt <= '0;
				if (row_end)
				begin
					row_cnt <= '0;
				end
				else
				begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
			else
			begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			win_valid <= 1'b0;
			win_last  <= 1'b0;
		end
		else if (en)
		begin
			win_valid <= in_fire && pos_ok;
			win_last  <= in_fire && col_end && row_end;
		end
	end

	a_row_range: assert property (@(posedge clk) disable iff (rst)
		row_cnt < coord_t'(`CONV_IMG_HEIGHT));

endmodule

//--- rtl/tap_multiply.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module tap_multiply (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en,
	input  logic                  win_valid,
	input  conv_pkg::tap_vec_t    win,
	input  conv_pkg::coord_t      win_row,
	input  conv_pkg::coord_t      win_col,
	input  logic                  win_last,
	input  conv_pkg::weight_mat_t weights,
	output logic                  prod_valid,
	output conv_pkg::prod_mat_t   prods,
	output conv_pkg::coord_t      prod_row,
	output conv_pkg::coord_t      prod_col,
	output logic                  prod_last
);

	import conv_pkg::*;

	prod_mat_t prod_next;

	// full product, rescaled to Q8.8 and truncated
	always_comb
	begin
		acc_t full;
		for (int t = 0; t < `CONV_TAPS; t++)
		begin
			for (int c = 0; c < `CONV_CHANNELS; c++)
			begin
				full = $signed(win[t]) * $signed(weights[t][c]);
				prod_next[t][c] = pixel_t'(full >>> `CONV_FRAC);
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prod_valid <= 1'b0;
			prod_last  <= 1'b0;
		end
		else if (en)
		begin
			prod_valid <= win_valid;
			prod_last  <= win_last;
		end
	end

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			prods    <= prod_next;
			prod_row <= win_row;
			prod_col <= win_col;
		end
	end

endmodule

//--- rtl/channel_accumulate.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module channel_accumulate (
	input  logic                clk,
	input  logic                rst,
	input  logic                en,
	input  logic                prod_valid,
	input  conv_pkg::prod_mat_t prods,
	input  conv_pkg::coord_t    prod_row,
	input  conv_pkg::coord_t    prod_col,
	input  logic                prod_last,
	input  conv_pkg::chan_vec_t biases,
	output logic                out_valid,
	output conv_pkg::chan_vec_t out_data,
	output conv_pkg::coord_t    out_row,
	output conv_pkg::coord_t    out_col,
	output logic                out_last
);

	import conv_pkg::*;

	chan_vec_t sum_next;

	// taps paired 0..7, tap 8 paired with the bias
	always_comb
	begin
		acc_t pair [4];
		acc_t tail;
		acc_t total;
		for (int c = 0; c < `CONV_CHANNELS; c++)
		begin
			for (int p = 0; p < 4; p++)
			begin
				pair[p] = acc_t'(prods[2*p][c]) + acc_t'(prods[2*p + 1][c]);
			end
			tail = acc_t'(prods[8][c]) + acc_t'(biases[c]);
			total = (pair[0] + pair[1]) + (pair[2] + pair[3]) + tail;
			// wraps modulo one word
			sum_next[c] = pixel_t'(total);
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end
		else if (en)
		begin
			out_valid <= prod_valid;
			out_last  <= prod_last;
		end
	end

	always_ff @(posedge clk)
	begin
		if (en)
		begin
			out_data <= sum_next;
			out_row  <= prod_row;
			out_col  <= prod_col;
		end
	end

	// result fields frozen while the consumer stalls
	a_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !en |=> $stable(out_data) && $stable(out_row) && $stable(out_col));

endmodule

//--- rtl/conv_layer.sv
`timescale 1ns/1ns

module conv_layer (
	input  logic                clk,
	input  logic                rst,
	input  logic                coeff_valid,
	input  conv_pkg::pixel_t    coeff_data,
	output logic                coeff_ready,
	input  logic                in_valid,
	input  conv_pkg::pixel_t    in_data,
	output logic                in_ready,
	output logic                out_valid,
	output conv_pkg::chan_vec_t out_data,
	output conv_pkg::coord_t    out_row,
	output conv_pkg::coord_t    out_col,
	output logic                out_last,
	input  logic                out_ready
);

	import conv_pkg::*;

	logic        stage_en;
	logic        in_fire;
	logic        coeff_loaded;
	weight_mat_t weights;
	chan_vec_t   biases;

	logic        win_valid;
	tap_vec_t    win;
	coord_t      win_row;
	coord_t      win_col;
	logic        win_last;

	logic        prod_valid;
	prod_mat_t   prods;
	coord_t      prod_row;
	coord_t      prod_col;
	logic        prod_last;

	// whole pipeline freezes while a result waits
	assign stage_en = !(out_valid && !out_ready);
	assign in_ready = stage_en && coeff_loaded;
	assign in_fire  = in_valid && in_ready;

	coeff_loader i_coeff_loader (
		.clk          (clk),
		.rst          (rst),
		.coeff_valid  (coeff_valid),
		.coeff_data   (coeff_data),
		.coeff_ready  (coeff_ready),
		.coeff_loaded (coeff_loaded),
		.weights      (weights),
		.biases       (biases)
	);

	conv_window i_conv_window (
		.clk       (clk),
		.rst       (rst),
		.en        (stage_en),
		.in_fire   (in_fire),
		.in_data   (in_data),
		.win_valid (win_valid),
		.win       (win),
		.win_row   (win_row),
		.win_col   (win_col),
		.win_last  (win_last)
	);

	tap_multiply i_tap_multiply (
		.clk        (clk),
		.rst        (rst),
		.en         (stage_en),
		.win_valid  (win_valid),
		.win        (win),
		.win_row    (win_row),
		.win_col    (win_col),
		.win_last   (win_last),
		.weights    (weights),
		.prod_valid (prod_valid),
		.prods      (prods),
		.prod_row   (prod_row),
		.prod_col   (prod_col),
		.prod_last  (prod_last)
	);

	channel_accumulate i_channel_accumulate (
		.clk        (clk),
		.rst        (rst),
		.en         (stage_en),
		.prod_valid (prod_valid),
		.prods      (prods),
		.prod_row   (prod_row),
		.prod_col   (prod_col),
		.prod_last  (prod_last),
		.biases     (biases),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_row    (out_row),
		.out_col    (out_col),
		.out_last   (out_last)
	);

	// a refused result is offered again unchanged
	a_stall_keep: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_last));

endmodule

//--- verification/conv_layer_tb.sv
`timescale 1ns/1ns
`include "conv_consts.svh"

module conv_layer_tb;

	import conv_pkg::*;

	localparam int NUM_ROWS    = 6;
	localparam int PIXELS      = `CONV_IMG_WIDTH * `CONV_IMG_HEIGHT;
	localparam int RESULTS     = (`CONV_IMG_WIDTH - 2) * (`CONV_IMG_HEIGHT - 2);
	localparam int CYCLE_LIMIT = `CONV_COEFF_COUNT + NUM_ROWS * PIXELS * 4 + 200;
	localparam int RAMP_STEP   = 37;

	localparam logic [1:0] PAT_CONST  = 2'd0;
	localparam logic [1:0] PAT_RAMP   = 2'd1;
	localparam logic [1:0] PAT_RANDOM = 2'd2;

	typedef struct packed {
		logic       load;
		logic       rand_coeff;
		logic [1:0] pattern;
		logic       gated;
		pixel_t     pix;
		pixel_t     w;
		pixel_t     b;
	} row_t;

	logic      clk = 1'b0;
	logic      rst;
	logic      coeff_valid;
	pixel_t    coeff_data;
	logic      coeff_ready;
	logic      in_valid;
	pixel_t    in_data;
	logic      in_ready;
	logic      out_valid;
	chan_vec_t out_data;
	coord_t    out_row;
	coord_t    out_col;
	logic      out_last;
	logic      out_ready;

	row_t        table_rows [NUM_ROWS];
	pixel_t      img [PIXELS];
	pixel_t      w_set [`CONV_TAPS][`CONV_CHANNELS];
	pixel_t      b_set [`CONV_CHANNELS];
	logic [15:0] lfsr_state;
	logic        gated_now = 1'b0;
	int          cycle = 0;

	chan_vec_t exp_data [$];
	coord_t    exp_row [$];
	coord_t    exp_col [$];
	logic      exp_last [$];

	logic      held_valid;
	chan_vec_t held_data;
	coord_t    held_row;
	coord_t    held_col;
	logic      held_last;
	int        pix_row;
	int        pix_col;
	logic      lat_armed;
	int        lat_start;
	int        results_seen = 0;

	conv_layer i_dut (
		.clk         (clk),
		.rst         (rst),
		.coeff_valid (coeff_valid),
		.coeff_data  (coeff_data),
		.coeff_ready (coeff_ready),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_ready    (in_ready),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.out_row     (out_row),
		.out_col     (out_col),
		.out_last    (out_last),
		.out_ready   (out_ready)
	);

	always #4 clk = !clk;

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_chan(input string name, input chan_vec_t got, input chan_vec_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			stop_run();
		end
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic rand_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	function automatic pixel_t rand_word();
		pixel_t v;
		for (int i = 0; i < `CONV_WORD; i++)
		begin
			v[i] = rand_bit();
		end
		return v;
	endfunction

	// Q8.8 product rescaled and cut to one word
	function automatic pixel_t scaled_product(input pixel_t p, input pixel_t w);
		int full;
		full = int'(p) * int'(w);
		return pixel_t'(full >>> `CONV_FRAC);
	endfunction

	task automatic build_frame(input row_t row);
		for (int i = 0; i < PIXELS; i++)
		begin
			case (row.pattern)
				PAT_CONST: img[i] = row.pix;
				PAT_RAMP:  img[i] = row.pix + pixel_t'(i * RAMP_STEP);
				default:   img[i] = rand_word();
			endcase
		end
	endtask

	// reference model gives one entry per window in raster order
	task automatic push_expected();
		chan_vec_t res;
		int        sum;
		int        px;
		for (int r = `CONV_KERNEL - 1; r < `CONV_IMG_HEIGHT; r++)
		begin
			for (int c = `CONV_KERNEL - 1; c < `CONV_IMG_WIDTH; c++)
			begin
				for (int ch = 0; ch < `CONV_CHANNELS; ch++)
				begin
					sum = int'(b_set[ch]);
					for (int t = 0; t < `CONV_TAPS; t++)
					begin
						px = (r - 2 + t / `CONV_KERNEL) * `CONV_IMG_WIDTH + c - 2 + t % `CONV_KERNEL;
						sum += int'(scaled_product(img[px], w_set[t][ch]));
					end
					res[ch] = pixel_t'(sum);
				end
				exp_data.push_back(res);
				exp_row.push_back(coord_t'(r - 2));
				exp_col.push_back(coord_t'(c - 2));
				exp_last.push_back(r == `CONV_IMG_HEIGHT - 1 && c == `CONV_IMG_WIDTH - 1);
			end
		end
	endtask

	task automatic send_coeff(input pixel_t word);
		coeff_valid <= 1'b1;
		coeff_data  <= word;
		do
		begin
			@(posedge clk);
			check_bit("in_ready", in_ready, 1'b0);
		end
		while (!coeff_ready);
	endtask

	task automatic load_coeffs(input row_t row);
		for (int t = 0; t < `CONV_TAPS; t++)
		begin
			for (int ch = 0; ch < `CONV_CHANNELS; ch++)
			begin
				w_set[t][ch] = row.rand_coeff ? rand_word() : row.w;
			end
		end
		for (int ch = 0; ch < `CONV_CHANNELS; ch++)
		begin
			b_set[ch] = row.rand_coeff ? rand_word() : row.b;
		end
		// weights in tap-major order, then the biases
		for (int t = 0; t < `CONV_TAPS; t++)
		begin
			for (int ch = 0; ch < `CONV_CHANNELS; ch++)
			begin
				send_coeff(w_set[t][ch]);
			end
		end
		for (int ch = 0; ch < `CONV_CHANNELS; ch++)
		begin
			send_coeff(b_set[ch]);
		end
		coeff_valid <= 1'b0;
		@(posedge clk);
		check_bit("coeff_ready", coeff_ready, 1'b0);
		check_bit("in_ready", in_ready, 1'b1);
	endtask

	task automatic apply_reset();
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("out_last", out_last, 1'b0);
		check_bit("in_ready", in_ready, 1'b0);
		check_bit("coeff_ready", coeff_ready, 1'b1);
	endtask

	task automatic drain_results();
		in_valid  <= 1'b0;
		out_ready <= 1'b1;
		while (exp_data.size() != 0)
		begin
			@(posedge clk);
		end
		@(posedge clk);
	endtask

	task automatic stream_frame(input row_t row);
		int idx;
		idx = 0;
		while (idx < PIXELS)
		begin
			in_valid  <= 1'b1;
			in_data   <= img[idx];
			out_ready <= row.gated ? rand_bit() : 1'b1;
			@(posedge clk);
			if (in_ready)
			begin
				idx++;
			end
		end
	endtask

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT)
		begin
			$display("timeout after %0d cycles, results are still missing", cycle);
			stop_run();
		end
	end

	// output checker sees the values from before each edge
	always @(posedge clk)
	begin
		if (rst)
		begin
			held_valid <= 1'b0;
			lat_armed  <= 1'b0;
			pix_row    <= 0;
			pix_col    <= 0;
		end
		else
		begin
			// last cycle was a stall
			if (held_valid)
			begin
				check_bit("out_valid", out_valid, 1'b1);
				check_chan("out_data", out_data, held_data);
				check_coord("out_row", out_row, held_row);
				check_coord("out_col", out_col, held_col);
				check_bit("out_last", out_last, held_last);
			end
			// no pixel taken while a result is refused
			if (out_valid && !out_ready)
			begin
				check_bit("in_ready", in_ready, 1'b0);
			end
			if (!out_valid)
			begin
				check_bit("out_last", out_last, 1'b0);
			end
			held_valid <= out_valid && !out_ready;
			held_data  <= out_data;
			held_row   <= out_row;
			held_col   <= out_col;
			held_last  <= out_last;
			if (out_valid && out_ready)
			begin
				if (exp_data.size() == 0)
				begin
					$display("result at row %0d, column %0d was not expected", out_row, out_col);
					stop_run();
				end
				else
				begin
					check_chan("out_data", out_data, exp_data.pop_front());
					check_coord("out_row", out_row, exp_row.pop_front());
					check_coord("out_col", out_col, exp_col.pop_front());
					check_bit("out_last", out_last, exp_last.pop_front());
					results_seen <= results_seen + 1;
				end
			end
			if (in_valid && in_ready)
			begin
				// first window of the frame completes here
				if (pix_row == 2 && pix_col == 2 && !gated_now)
				begin
					lat_armed <= 1'b1;
					lat_start <= cycle;
				end
				pix_col <= (pix_col == `CONV_IMG_WIDTH - 1) ? 0 : pix_col + 1;
				if (pix_col == `CONV_IMG_WIDTH - 1)
				begin
					pix_row <= (pix_row == `CONV_IMG_HEIGHT - 1) ? 0 : pix_row + 1;
				end
			end
			if (lat_armed && cycle == lat_start + 2)
			begin
				check_bit("out_valid", out_valid, 1'b0);
			end
			if (lat_armed && cycle == lat_start + 3)
			begin
				check_bit("out_valid", out_valid, 1'b1);
				lat_armed <= 1'b0;
			end
		end
	end

	initial
	begin
		lfsr_state = 16'd79;
		rst         <= 1'b1;
		coeff_valid <= 1'b0;
		coeff_data  <= '0;
		in_valid    <= 1'b0;
		in_data     <= '0;
		out_ready   <= 1'b1;
		// load, random coeffs, pattern, gated, pixel, weight, bias
		table_rows[0] = '{1'b1, 1'b0, PAT_CONST, 1'b0, 16'h0180, 16'h00c0, 16'h0020};
		table_rows[1] = '{1'b0, 1'b0, PAT_CONST, 1'b1, 16'hfe40, 16'h00c0, 16'h0020};
		table_rows[2] = '{1'b1, 1'b1, PAT_RAMP, 1'b0, 16'h0010, 16'h0000, 16'h0000};
		table_rows[3] = '{1'b0, 1'b1, PAT_RANDOM, 1'b0, 16'h0000, 16'h0000, 16'h0000};
		table_rows[4] = '{1'b0, 1'b1, PAT_RANDOM, 1'b1, 16'h0000, 16'h0000, 16'h0000};
		table_rows[5] = '{1'b0, 1'b1, PAT_RAMP, 1'b1, 16'hff00, 16'h0000, 16'h0000};
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			if (table_rows[r].load)
			begin
				drain_results();
				apply_reset();
				load_coeffs(table_rows[r]);
			end
			gated_now = table_rows[r].gated;
			build_frame(table_rows[r]);
			push_expected();
			stream_frame(table_rows[r]);
		end
		drain_results();
		if (results_seen == NUM_ROWS * RESULTS && exp_data.size() == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("%0d results seen, %0d expected", results_seen, NUM_ROWS * RESULTS);
			stop_run();
		end
	end

endmodule

//--- src.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/coeff_loader.sv
rtl/conv_window.sv
rtl/tap_multiply.sv
rtl/channel_accumulate.sv
rtl/conv_layer.sv
verification/conv_layer_tb.sv

//--- Bender.yml
package:
  name: conv_layer

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/conv_pkg.sv
      - rtl/coeff_loader.sv
      - rtl/conv_window.sv
      - rtl/tap_multiply.sv
      - rtl/channel_accumulate.sv
      - rtl/conv_layer.sv
  - target: simulation
    files:
      - verification/conv_layer_tb.sv
